//--- Makefile
# Verilator build and run of the pipelined core testbench
# The run passes only if the log holds the pass line

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module procTb -f proc.f -o procSim

run: compile
	-./obj_dir/procSim > sim.log 2>&1
	cat sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- decode.sv
//////////////////////////////
// Decode stage
// Register file with write bypass, control decode,
// load-use stall and the illegal opcode trap.
// Illegal instructions continue down the pipe as bubbles.
//////////////////////////////
`timescale 1ns/100ps
module decode (
   input  logic                 clk,
   input  logic                 reset,
   input  procPkg::fetchDecodeT fetchIn,
   input  logic                 redirect,
   input  procPkg::wbT          wb,
   output logic                 stall,
   output logic                 haltSeen,
   output logic                 err,
   output procPkg::decodeExecT  decodeOut
);

   procPkg::instrU instr;
   procPkg::ctrlT ctrl;
   procPkg::decodeExecT nextOut;
   logic illegal;
   logic usesRs;
   logic usesRt;
   logic usesRd;
   logic [procPkg::wordWidth-1:0] regs [8];

   // Same-cycle writeback wins over the stored value
   function automatic logic [procPkg::wordWidth-1:0] readReg(input logic [2:0] r);
      return (wb.valid && wb.rd == r) ? wb.data : regs[r];
   endfunction

   assign instr = fetchIn.instr;

   always_comb begin
      ctrl = '0;
      illegal = 1'b0;
      usesRs = 1'b1;
      usesRt = 1'b0;
      usesRd = 1'b0;
      case (instr.r.opcode)
         procPkg::HALT: begin
            ctrl.halt = 1'b1;
            usesRs = 1'b0;
         end
         procPkg::ADD, procPkg::SUB, procPkg::AND, procPkg::XOR: begin
            // Opcodes 1 to 4 line up with the ALU encoding plus one
            ctrl.aluOp = procPkg::aluOpE'(instr.r.opcode[1:0] - 2'd1);
            ctrl.regWrite = 1'b1;
            usesRt = 1'b1;
         end
         procPkg::ADDI: begin
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         procPkg::LD: begin
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.memRead = 1'b1;
         end
         procPkg::ST: begin
            ctrl.useImm = 1'b1;
            ctrl.memWrite = 1'b1;
            usesRd = 1'b1;
         end
         procPkg::BEQZ: ctrl.branchZero = 1'b1;
         procPkg::BNEZ: ctrl.branchNonZero = 1'b1;
         default: begin
            illegal = 1'b1;
            usesRs = 1'b0;
         end
      endcase
   end

   // Load in execute feeding this instruction
   assign stall = fetchIn.valid && decodeOut.valid && decodeOut.ctrl.memRead &&
                  ((usesRs && decodeOut.rd == instr.r.rs) ||
                   (usesRt && decodeOut.rd == instr.r.rt) ||
                   (usesRd && decodeOut.rd == instr.r.rd));
   assign haltSeen = fetchIn.valid && ctrl.halt;

   always_comb begin
      nextOut.valid = fetchIn.valid && !illegal && !stall && !redirect;
      nextOut.ctrl = ctrl;
      nextOut.rs = instr.r.rs;
      nextOut.rt = instr.r.rt;
      nextOut.rd = instr.r.rd;
      nextOut.opA = readReg(instr.r.rs);
      nextOut.opB = readReg(instr.r.rt);
      nextOut.storeData = readReg(instr.r.rd);
      nextOut.imm = {{(procPkg::wordWidth-6){instr.i.imm[5]}}, instr.i.imm};
      nextOut.pc = fetchIn.pc;
   end

   always_ff @(posedge clk) begin
      if (wb.valid) begin
         regs[wb.rd] <= wb.data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         decodeOut.valid <= 1'b0;
         err <= 1'b0;
      end else begin
         decodeOut <= nextOut;
         if (fetchIn.valid && illegal && !redirect) begin
            err <= 1'b1;
         end
      end
   end

endmodule

//--- execute.sv
//////////////////////////////
// Execute stage
// Operand forwarding, ALU and address add, branch resolution.
// A taken branch redirects fetch and squashes decode.
//////////////////////////////
`timescale 1ns/100ps
module execute (
   input  logic                          clk,
   input  logic                          reset,
   input  procPkg::decodeExecT           execIn,
   input  procPkg::wbT                   wb,
   output logic                          redirect,
   output logic [procPkg::wordWidth-1:0] redirectPc,
   output procPkg::execMemT              execOut
);

   logic [procPkg::wordWidth-1:0] srcA;
   logic [procPkg::wordWidth-1:0] srcB;
   logic [procPkg::wordWidth-1:0] fwdStore;
   logic [procPkg::wordWidth-1:0] aluB;
   logic [procPkg::wordWidth-1:0] result;

   // Youngest writer first. A load still in memory has no data yet,
   // the decode stall keeps it from being needed here
   function automatic logic [procPkg::wordWidth-1:0] selectOperand(
      input logic [2:0]                    r,
      input logic [procPkg::wordWidth-1:0] regVal
   );
      if (execOut.valid && execOut.ctrl.regWrite && !execOut.ctrl.memRead &&
          execOut.rd == r) begin
         return execOut.aluResult;
      end else if (wb.valid && wb.rd == r) begin
         return wb.data;
      end
      return regVal;
   endfunction

   assign srcA = selectOperand(execIn.rs, execIn.opA);
   assign srcB = selectOperand(execIn.rt, execIn.opB);
   assign fwdStore = selectOperand(execIn.rd, execIn.storeData);
   assign aluB = execIn.ctrl.useImm ? execIn.imm : srcB;

   always_comb begin
      case (execIn.ctrl.aluOp)
         procPkg::aluAdd: result = srcA + aluB;
         procPkg::aluSub: result = srcA - aluB;
         procPkg::aluAnd: result = srcA & aluB;
         default:         result = srcA ^ aluB;
      endcase
   end

   assign redirect = execIn.valid &&
                     ((execIn.ctrl.branchZero && srcA == '0) ||
                      (execIn.ctrl.branchNonZero && srcA != '0));
   assign redirectPc = execIn.pc + 1'b1 + execIn.imm;

   always_ff @(posedge clk) begin
      if (reset) begin
         execOut.valid <= 1'b0;
      end else begin
         execOut.valid <= execIn.valid;
         execOut.ctrl <= execIn.ctrl;
         execOut.rd <= execIn.rd;
         execOut.aluResult <= result;
         execOut.storeData <= fwdStore;
      end
   end

endmodule

//--- fetch.sv
//////////////////////////////
// Fetch stage
// Instruction memory filled through the load port while idle,
// then the pc runs from address 0 once start arrives.
// Holds on stall, squashes on redirect, stops after a HALT.
//////////////////////////////
`timescale 1ns/100ps
module fetch #(
   parameter int imemDepth = 256
) (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                start,
   input  logic                                loadValid,
   input  logic [$clog2(imemDepth)-1:0]        loadAddr,
   input  logic [procPkg::wordWidth-1:0]       loadData,
   input  logic                                stall,
   input  logic                                haltSeen,
   input  logic                                redirect,
   input  logic [procPkg::wordWidth-1:0]       redirectPc,
   output logic                                loadReady,
   output procPkg::fetchDecodeT                fetchOut
);

   localparam int addrWidth = $clog2(imemDepth);

   logic [procPkg::wordWidth-1:0] imem [imemDepth];
   logic [procPkg::wordWidth-1:0] pc;
   logic running;
   logic stopped;
   logic issue;

   assign loadReady = !running;
   // Start itself counts as the first running cycle
   assign issue = (running || start) && !stopped;

   always_ff @(posedge clk) begin
      if (loadValid && loadReady) begin
         imem[loadAddr] <= loadData;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         running <= 1'b0;
         stopped <= 1'b0;
         pc <= '0;
         fetchOut.valid <= 1'b0;
      end else if (issue) begin
         running <= 1'b1;
         if (redirect) begin
            pc <= redirectPc;
            fetchOut.valid <= 1'b0;
         end else if (haltSeen) begin
            stopped <= 1'b1;
            fetchOut.valid <= 1'b0;
         end else if (!stall) begin
            fetchOut.valid <= 1'b1;
            fetchOut.pc <= pc;
            fetchOut.instr <= imem[pc[addrWidth-1:0]];
            pc <= pc + 1'b1;
         end
      end
   end

endmodule

//--- memory.sv
//////////////////////////////
// Memory stage
// Word-addressed data memory and the writeback select.
// Its output register is the retirement point of the core.
//////////////////////////////
`timescale 1ns/100ps
module memory #(
   parameter int dmemDepth = 256
) (
   input  logic             clk,
   input  logic             reset,
   input  procPkg::execMemT memIn,
   output procPkg::wbT      wbOut,
   output logic             halted
);

   localparam int addrWidth = $clog2(dmemDepth);

   logic [procPkg::wordWidth-1:0] dmem [dmemDepth];
   logic [addrWidth-1:0] addr;
   logic [procPkg::wordWidth-1:0] loadWord;

   assign addr = memIn.aluResult[addrWidth-1:0];
   assign loadWord = dmem[addr];

   always_ff @(posedge clk) begin
      if (memIn.valid && memIn.ctrl.memWrite) begin
         dmem[addr] <= memIn.storeData;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wbOut.valid <= 1'b0;
         halted <= 1'b0;
      end else begin
         wbOut.valid <= memIn.valid && memIn.ctrl.regWrite;
         wbOut.rd <= memIn.rd;
         wbOut.data <= memIn.ctrl.memRead ? loadWord : memIn.aluResult;
         if (memIn.valid && memIn.ctrl.halt) begin
            halted <= 1'b1;
         end
      end
   end

endmodule

//--- proc.f
procPkg.sv
fetch.sv
decode.sv
execute.sv
memory.sv
proc.sv
proc_checker.sv
procTb.sv

//--- proc.sv
//////////////////////////////
// Top level of the pipelined core
// Load the program while loadReady is high, pulse start,
// then watch trace until halted rises.
//////////////////////////////
`timescale 1ns/100ps
module proc #(
   parameter int imemDepth = 256,
   parameter int dmemDepth = 256
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          start,
   input  logic                          loadValid,
   input  logic [$clog2(imemDepth)-1:0]  loadAddr,
   input  logic [procPkg::wordWidth-1:0] loadData,
   output logic                          loadReady,
   output procPkg::wbT                   trace,
   output logic                          halted,
   output logic                          err
);

   procPkg::fetchDecodeT fetchDecode;
   procPkg::decodeExecT decodeExec;
   procPkg::execMemT execMem;
   logic stall;
   logic haltSeen;
   logic redirect;
   logic [procPkg::wordWidth-1:0] redirectPc;

   fetch #(
      .imemDepth(imemDepth)
   ) fetchStage (
      .clk(clk),
      .reset(reset),
      .start(start),
      .loadValid(loadValid),
      .loadAddr(loadAddr),
      .loadData(loadData),
      .stall(stall),
      .haltSeen(haltSeen),
      .redirect(redirect),
      .redirectPc(redirectPc),
      .loadReady(loadReady),
      .fetchOut(fetchDecode)
   );

   decode decodeStage (
      .clk(clk),
      .reset(reset),
      .fetchIn(fetchDecode),
      .redirect(redirect),
      .wb(trace),
      .stall(stall),
      .haltSeen(haltSeen),
      .err(err),
      .decodeOut(decodeExec)
   );

   execute executeStage (
      .clk(clk),
      .reset(reset),
      .execIn(decodeExec),
      .wb(trace),
      .redirect(redirect),
      .redirectPc(redirectPc),
      .execOut(execMem)
   );

   // Writeback register doubles as the trace port
   memory #(
      .dmemDepth(dmemDepth)
   ) memoryStage (
      .clk(clk),
      .reset(reset),
      .memIn(execMem),
      .wbOut(trace),
      .halted(halted)
   );

endmodule

//--- procPkg.sv
//////////////////////////////
// Shared definitions for the five-stage 16-bit core
// Word width, opcodes, the two instruction formats and the
// registers that travel between the pipeline stages.
// Stage modules refer to these by scoped name.
//////////////////////////////
package procPkg;

   localparam int wordWidth = 16;

   typedef enum logic [3:0] {
      HALT = 4'd0,
      ADD  = 4'd1,
      SUB  = 4'd2,
      AND  = 4'd3,
      XOR  = 4'd4,
      ADDI = 4'd8,
      LD   = 4'd9,
      ST   = 4'd10,
      BEQZ = 4'd12,
      BNEZ = 4'd13
   } opcodeE;

   // Register format
   typedef struct packed {
      opcodeE     opcode;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] pad;
   } rFmtT;

   // Immediate format, the rt and pad bits carry the offset
   typedef struct packed {
      opcodeE            opcode;
      logic [2:0]        rd;
      logic [2:0]        rs;
      logic signed [5:0] imm;
   } iFmtT;

   typedef union packed {
      rFmtT r;
      iFmtT i;
   } instrU;

   typedef enum logic [1:0] {
      aluAdd = 2'd0,
      aluSub = 2'd1,
      aluAnd = 2'd2,
      aluXor = 2'd3
   } aluOpE;

   typedef struct packed {
      aluOpE aluOp;
      logic  useImm;
      logic  regWrite;
      logic  memRead;
      logic  memWrite;
      logic  branchZero;
      logic  branchNonZero;
      logic  halt;
   } ctrlT;

   typedef struct packed {
      logic                 valid;
      logic [wordWidth-1:0] pc;
      logic [wordWidth-1:0] instr;
   } fetchDecodeT;

   typedef struct packed {
      logic                 valid;
      ctrlT                 ctrl;
      logic [2:0]           rs;
      logic [2:0]           rt;
      logic [2:0]           rd;
      logic [wordWidth-1:0] opA;
      logic [wordWidth-1:0] opB;
      logic [wordWidth-1:0] storeData;
      logic [wordWidth-1:0] imm;
      logic [wordWidth-1:0] pc;
   } decodeExecT;

   typedef struct packed {
      logic                 valid;
      ctrlT                 ctrl;
      logic [2:0]           rd;
      logic [wordWidth-1:0] aluResult;
      logic [wordWidth-1:0] storeData;
   } execMemT;

   typedef struct packed {
      logic                 valid;
      logic [2:0]           rd;
      logic [wordWidth-1:0] data;
   } wbT;

endpackage

//--- procTb.sv
//////////////////////////////
// Testbench for the pipelined core
// Reads programs and their expected writeback traces from
// proc_input.txt, loads each one through the load port with
// pseudo-random gaps, runs it and checks trace, halted and err.
//////////////////////////////
`timescale 1ns/100ps
module procTb;

   localparam int imemDepth = 256;
   localparam int dmemDepth = 256;
   localparam int addrWidth = $clog2(imemDepth);
   localparam int fileDepth = 128;

   logic                          clk;
   logic                          reset;
   logic                          start;
   logic                          loadValid;
   logic [addrWidth-1:0]          loadAddr;
   logic [procPkg::wordWidth-1:0] loadData;
   logic                          loadReady;
   procPkg::wbT                   trace;
   logic                          halted;
   logic                          err;

   // Kind nibble, register nibble, 16-bit value
   logic [23:0] stimulus [fileDepth];
   logic [procPkg::wordWidth-1:0] progWords [$];
   logic [2:0] expRd [$];
   logic [procPkg::wordWidth-1:0] expData [$];
   logic expErr;
   logic [7:0] lfsr;
   int pos;
   int watchdogCycles;
   int programsRun;
   int checkedEntries;

   proc #(
      .imemDepth(imemDepth),
      .dmemDepth(dmemDepth)
   ) UUT (
      .clk(clk),
      .reset(reset),
      .start(start),
      .loadValid(loadValid),
      .loadAddr(loadAddr),
      .loadData(loadData),
      .loadReady(loadReady),
      .trace(trace),
      .halted(halted),
      .err(err)
   );

   always begin
      #5 clk = ~clk;
   end

   // Galois form of x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] lfsrNext(input logic [7:0] s);
      return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
   endfunction

   task automatic abortRun();
      $display("SOME TESTS FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic readProgram();
      progWords.delete();
      expRd.delete();
      expData.delete();
      while (pos < fileDepth && stimulus[pos][23:20] != 4'h3) begin
         case (stimulus[pos][23:20])
            4'h1: progWords.push_back(stimulus[pos][15:0]);
            4'h2: begin
               expRd.push_back(stimulus[pos][18:16]);
               expData.push_back(stimulus[pos][15:0]);
            end
            default: begin
               $display("Input file entry %0d has an unknown kind %h", pos,
                        stimulus[pos][23:20]);
               abortRun();
            end
         endcase
         pos++;
      end
      if (pos >= fileDepth) begin
         $display("Input file ended inside a program");
         abortRun();
      end
      expErr = stimulus[pos][0];
      pos++;
   endtask

   task automatic resetCore();
      @(posedge clk);
      #1;
      reset = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
   endtask

   // Two LFSR bits per word give an idle gap of 0 to 3 cycles
   task automatic loadProgram();
      int gap;
      for (int i = 0; i < progWords.size(); i++) begin
         gap = 0;
         repeat (2) begin
            gap = (gap << 1) | int'(lfsr[0]);
            lfsr = lfsrNext(lfsr);
         end
         if (gap > 0) begin
            repeat (gap) @(posedge clk);
            #1;
         end
         assert (loadReady) else begin
            $display("ERROR at %0t: loadReady expected 1 got %b", $time, loadReady);
            abortRun();
         end
         loadValid = 1'b1;
         loadAddr = i[addrWidth-1:0];
         loadData = progWords[i];
         @(posedge clk);
         #1;
         loadValid = 1'b0;
      end
   endtask

   task automatic runProgram();
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      assert (!loadReady) else begin
         $display("ERROR at %0t: loadReady expected 0 got %b", $time, loadReady);
         abortRun();
      end
      while (!halted) @(negedge clk);
      assert (expRd.size() == 0) else begin
         $display("Core halted with %0d expected trace entries missing", expRd.size());
         abortRun();
      end
      // A few more cycles so a late retirement would be caught
      repeat (3) @(negedge clk);
      assert (err == expErr) else begin
         $display("ERROR at %0t: err expected %b got %b", $time, expErr, err);
         abortRun();
      end
   endtask

   always @(negedge clk) begin
      if (!reset && trace.valid) begin
         assert (!halted) else begin
            $display("Trace entry for r%0d retired after halted", trace.rd);
            abortRun();
         end
         assert (expRd.size() > 0) else begin
            $display("Trace entry for r%0d beyond the expected ones", trace.rd);
            abortRun();
         end
         assert (trace.rd == expRd[0]) else begin
            $display("ERROR at %0t: trace.rd expected %0d got %0d", $time, expRd[0],
                     trace.rd);
            abortRun();
         end
         assert (trace.data == expData[0]) else begin
            $display("ERROR at %0t: trace.data expected %h got %h", $time, expData[0],
                     trace.data);
            abortRun();
         end
         void'(expRd.pop_front());
         void'(expData.pop_front());
         checkedEntries++;
      end
   end

   // Budget of 20 cycles per word, plus loading and resets
   initial begin
      wait (watchdogCycles > 0);
      repeat (watchdogCycles) @(posedge clk);
      $display("Timeout: the programs did not finish within %0d cycles", watchdogCycles);
      abortRun();
   end

   initial begin
      int words;
      clk = 1'b0;
      reset = 1'b1;
      start = 1'b0;
      loadValid = 1'b0;
      loadAddr = '0;
      loadData = '0;
      lfsr = 8'd95;
      pos = 0;
      words = 0;
      programsRun = 0;
      checkedEntries = 0;
      $readmemh("proc_input.txt", stimulus);
      for (int k = 0; k < fileDepth; k++) begin
         if (stimulus[k][23:20] == 4'h1) begin
            words++;
         end
      end
      watchdogCycles = words * 20 + words * 4 + 40;
      while (pos < fileDepth && stimulus[pos][23:20] != 4'hf) begin
         readProgram();
         resetCore();
         loadProgram();
         runProgram();
         programsRun++;
      end
      if (programsRun > 0 && checkedEntries > 0) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         $display("No complete program was found in the input file");
         abortRun();
      end
   end

endmodule

//--- proc_checker.sv
//////////////////////////////
// Bound checks on the outside ports of the core
// Load port closed while running, nothing retires
// after halt, err is sticky until reset.
//////////////////////////////
`timescale 1ns/100ps
module procChecker (
   input logic        clk,
   input logic        reset,
   input logic        loadReady,
   input procPkg::wbT trace,
   input logic        halted,
   input logic        err
);

   loadClosed: assert property (@(posedge clk) disable iff (reset)
      (halted || trace.valid) |-> !loadReady)
      else $error("loadReady high while the core runs");

   quietAfterHalt: assert property (@(posedge clk) disable iff (reset)
      halted |-> !trace.valid)
      else $error("trace.valid seen after halted");

   // Only a reset may clear the trap flag
   errSticky: assert property (@(posedge clk) disable iff (reset)
      $fell(err) |-> $past(reset))
      else $error("err fell without a reset");

endmodule

bind proc procChecker procCheck (
   .clk(clk),
   .reset(reset),
   .loadReady(loadReady),
   .trace(trace),
   .halted(halted),
   .err(err)
);

//--- proc_input.txt
// Six hex digits per line: kind, register, 16-bit value
// Kind 1 program word, 2 expected trace rd and data, 3 end of program with err, f end
104248 // XOR  r1,r1,r1
108245 // ADDI r1,r1,5
10847D // ADDI r2,r1,-3
101650 // ADD  r3,r1,r2
1028C8 // SUB  r4,r3,r1
103B18 // AND  r5,r4,r3
104D48 // XOR  r6,r5,r1
10A642 // ST   r3,[r1+2]
109E85 // LD   r7,[r2+5]
101FC8 // ADD  r7,r7,r1 after the load
108D81 // loop: ADDI r6,r6,1
1084BF // ADDI r2,r2,-1
10D0BD // BNEZ r2,loop
10C041 // BEQZ r1,+1 not taken
1086C1 // ADDI r3,r3,1
101998 // ADD  r4,r6,r3
100000 // HALT
108241 // ADDI r1,r1,1 never fetched
210000
210005
220002
230007
240002
250002
260007
270007
27000C
260008
220001
260009
220000
230008
240011
300000
104248 // XOR  r1,r1,r1
108447 // ADDI r2,r1,7
105249 // illegal opcode 5
1086BE // ADDI r3,r2,-2
10A644 // ST   r3,[r1+4]
109844 // LD   r4,[r1+4]
102B10 // SUB  r5,r4,r2 after the load
10C041 // BEQZ r1,+1 taken
108D89 // ADDI r6,r6,9 flushed
104D58 // XOR  r6,r5,r3
100000 // HALT
210000
220007
230005
240005
25FFFE
26FFFB
300001
f00000
